// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,
        opOpImm = 7'b0010011,
        opOp    = 7'b0110011
    } opcodeT;

    // ALU operation select
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } aluOpT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    // Same instruction word, two field layouts
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    typedef enum logic [1:0] {
        clsAlu    = 2'd0,
        clsAluImm = 2'd1,
        clsLoad   = 2'd2,
        clsNone   = 2'd3
    } instrClassT;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        instrClassT  cls;
    } decodedT;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wbReqT;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    // Trace record, one per instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rdWe;
        logic [31:0] value;
    } retireT;

endpackage

`default_nettype wire

// File: src/aluControl.sv
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  rvPkg::opcodeT opcode,
    input  logic [2:0]    funct3,
    input  logic          bit30,
    output rvPkg::aluOpT  aluOp
);
    import rvPkg::*;

    always_comb begin
        case (opcode)
            opOp: begin
                // Register form, bit 30 picks SUB and SRA
                case (funct3)
                    3'b000: aluOp = bit30 ? SUB : ADD;
                    3'b001: aluOp = SLL;
                    3'b010: aluOp = SLT;
                    3'b011: aluOp = SLTU;
                    3'b100: aluOp = XOR;
                    3'b101: aluOp = bit30 ? SRA : SRL;
                    3'b110: aluOp = OR;
                    3'b111: aluOp = AND;
                    default: aluOp = ADD;
                endcase
            end
            opOpImm: begin
                // Immediate form, no SUBI so bit 30 only matters for shifts
                case (funct3)
                    3'b000: aluOp = ADD;
                    3'b001: aluOp = SLL;
                    3'b010: aluOp = SLT;
                    3'b011: aluOp = SLTU;
                    3'b100: aluOp = XOR;
                    3'b101: aluOp = bit30 ? SRA : SRL;
                    3'b110: aluOp = OR;
                    3'b111: aluOp = AND;
                    default: aluOp = ADD;
                endcase
            end
            // Load address is rs1 plus offset
            opLoad: aluOp = ADD;
            default: aluOp = ADD;
        endcase
    end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOpT op,
    output logic [31:0]  y
);
    import rvPkg::*;

    logic [4:0] shamt;

    // Shift amount from the low bits only
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:  y = a + b;
            SUB:  y = a - b;
            SLL:  y = a << shamt;
            SLT:  y = {31'd0, $signed(a) < $signed(b)};
            SLTU: y = {31'd0, a < b};
            XOR:  y = a ^ b;
            SRL:  y = a >> shamt;
            SRA:  y = $unsigned($signed(a) >>> shamt);
            OR:   y = a | b;
            AND:  y = a & b;
            default: y = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous read, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// File: src/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  rvPkg::instrT   instr,
    output rvPkg::decodedT dec
);
    import rvPkg::*;

    logic [11:0] imm12;

    // Immediate taken through the I-type view
    assign imm12 = instr.i.imm12;

    always_comb begin
        // Register fields sit at the same place in both formats
        dec.rs1 = instr.r.rs1;
        dec.rs2 = instr.r.rs2;
        dec.rd  = instr.r.rd;
        dec.imm = {{20{imm12[11]}}, imm12};

        case (instr.r.opcode)
            opOp:    dec.cls = clsAlu;
            opOpImm: dec.cls = clsAluImm;
            opLoad: begin
                // Only LW is supported, other widths retire as no-ops
                if (instr.i.funct3 == 3'b010) begin
                    dec.cls = clsLoad;
                end else begin
                    dec.cls = clsNone;
                end
            end
            default: dec.cls = clsNone;
        endcase
    end

endmodule

`default_nettype wire

// File: src/coreControl.sv
`timescale 1ns/1ps
`default_nettype none

module coreControl #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    output rvPkg::wbReqT    wbReq,
    input  rvPkg::wbRspT    wbRsp,
    output rvPkg::instrT    instr,
    input  rvPkg::decodedT  dec,
    input  logic [31:0]     rs1Val,
    input  logic [31:0]     rs2Val,
    output logic [31:0]     aluA,
    output logic [31:0]     aluB,
    input  logic [31:0]     aluY,
    output logic            rfWe,
    output logic [4:0]      rfWaddr,
    output logic [31:0]     rfWdata,
    output logic            retireValid,
    output rvPkg::retireT   retire
);
    import rvPkg::*;

    typedef enum logic [1:0] {
        sFetch = 2'd0,
        sExec  = 2'd1,
        sLoad  = 2'd2,
        sWrite = 2'd3
    } stateT;

    stateT       state;
    logic [31:0] pc;
    logic [31:0] loadAdr;
    logic [31:0] loadData;
    logic        cyc;
    logic        rdWe;

    // Sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sFetch;
            pc    <= resetPc;
            cyc   <= 1'b0;
        end else begin
            case (state)
                sFetch: begin
                    // Idle only right after reset, open the first cycle
                    if (!cyc) begin
                        cyc <= 1'b1;
                    end else if (wbRsp.ack) begin
                        cyc   <= 1'b0;
                        state <= sExec;
                    end
                end
                sExec: begin
                    if (dec.cls == clsLoad) begin
                        cyc   <= 1'b1;
                        state <= sLoad;
                    end else begin
                        pc    <= pc + 32'd4;
                        cyc   <= 1'b1;
                        state <= sFetch;
                    end
                end
                sLoad: begin
                    if (wbRsp.ack) begin
                        cyc   <= 1'b0;
                        state <= sWrite;
                    end
                end
                sWrite: begin
                    pc    <= pc + 32'd4;
                    cyc   <= 1'b1;
                    state <= sFetch;
                end
                default: state <= sFetch;
            endcase
        end
    end

    // Instruction, load address and load data
    always_ff @(posedge clk) begin
        if ((state == sFetch) && cyc && wbRsp.ack) begin
            instr <= wbRsp.dat;
        end
        if (state == sExec) begin
            loadAdr <= {aluY[31:2], 2'b00};
        end
        if ((state == sLoad) && wbRsp.ack) begin
            loadData <= wbRsp.dat;
        end
    end

    // Read-only master, full word lanes
    always_comb begin
        wbReq.cyc = cyc;
        wbReq.stb = cyc;
        wbReq.we  = 1'b0;
        wbReq.sel = 4'hF;
        wbReq.adr = (state == sLoad) ? loadAdr : pc;
        wbReq.dat = 32'd0;
    end

    // Operand b is rs2 only for the register form
    assign aluA = rs1Val;
    assign aluB = (dec.cls == clsAlu) ? rs2Val : dec.imm;

    // Retire at the end of EXEC, or after the load data arrives
    assign retireValid = ((state == sExec) && (dec.cls != clsLoad)) || (state == sWrite);
    assign rdWe        = (dec.rd != 5'd0) && (dec.cls != clsNone);

    assign rfWe    = retireValid && rdWe;
    assign rfWaddr = dec.rd;
    assign rfWdata = (state == sWrite) ? loadData : aluY;

    always_comb begin
        retire.pc    = pc;
        retire.rd    = dec.rd;
        retire.rdWe  = rdWe;
        retire.value = rfWdata;
    end

endmodule

`default_nettype wire

// File: src/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    output rvPkg::wbReqT  wbReq,
    input  rvPkg::wbRspT  wbRsp,
    output logic          retireValid,
    output rvPkg::retireT retire
);
    import rvPkg::*;

    instrT       instr;
    decodedT     dec;
    aluOpT       aluOp;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluY;
    logic        rfWe;
    logic [4:0]  rfWaddr;
    logic [31:0] rfWdata;

    coreControl #(
        .resetPc(resetPc)
    ) control (
        .clk        (clk),
        .rst        (rst),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .instr      (instr),
        .dec        (dec),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .aluA       (aluA),
        .aluB       (aluB),
        .aluY       (aluY),
        .rfWe       (rfWe),
        .rfWaddr    (rfWaddr),
        .rfWdata    (rfWdata),
        .retireValid(retireValid),
        .retire     (retire)
    );

    instrDecode decode (
        .instr(instr),
        .dec  (dec)
    );

    // Bit 30 is funct7[5] in the register view
    aluControl aluCtrl (
        .opcode(instr.r.opcode),
        .funct3(instr.r.funct3),
        .bit30 (instr.r.funct7[5]),
        .aluOp (aluOp)
    );

    alu alu0 (
        .a (aluA),
        .b (aluB),
        .op(aluOp),
        .y (aluY)
    );

    regFile regs (
        .clk   (clk),
        .rst   (rst),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .rdata1(rs1Val),
        .rdata2(rs2Val),
        .we    (rfWe),
        .waddr (rfWaddr),
        .wdata (rfWdata)
    );

endmodule

`default_nettype wire

// File: verif/execCore_sva.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreSva (
    input logic         clk,
    input logic         rst,
    input rvPkg::wbReqT wbReq,
    input rvPkg::wbRspT wbRsp,
    input logic         retireValid
);

    // Number of assertion failures so far
    int failCount = 0;

    // Strobe only inside a bus cycle
    stbInCyc: assert property (@(posedge clk) disable iff (rst) wbReq.stb |-> wbReq.cyc)
        else begin
            failCount++;
            $error("stb high without cyc");
        end

    // Request held until the slave acknowledges
    holdUntilAck: assert property (@(posedge clk) disable iff (rst)
        (wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr)))
        else begin
            failCount++;
            $error("stb or adr changed before ack");
        end

    // Read-only master
    neverWrite: assert property (@(posedge clk) disable iff (rst) !wbReq.we)
        else begin
            failCount++;
            $error("we raised");
        end

    noRetireInCycle: assert property (@(posedge clk) disable iff (rst)
        !(retireValid && wbReq.cyc))
        else begin
            failCount++;
            $error("retireValid during a bus cycle");
        end

endmodule

`default_nettype wire

// File: verif/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;
    import rvPkg::*;

    localparam logic [31:0] resetPc = 32'h0000_0100;
    localparam int numInstr = 400;
    // Two bus cycles of up to five clocks plus three, per instruction
    localparam int timeoutNs = numInstr * (2 * 5 + 3) * 8 + 2000;

    logic        clk;
    logic        rst;
    wbReqT       wbReq;
    wbRspT       wbRsp;
    logic        retireValid;
    retireT      retire;

    integer      seed = 32'h26fe_c71f;
    logic [31:0] prog [0:numInstr-1];
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelPc;
    logic [31:0] busAdrQ [$];
    int          retiredCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          waitLeft;
    logic        busBusy;

    execCore #(
        .resetPc(resetPc)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .retireValid(retireValid),
        .retire     (retire)
    );

    bind execCore execCoreSva busChecks (
        .clk        (clk),
        .rst        (rst),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp),
        .retireValid(retireValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    // Program region holds code, everything else a pattern of the address
    function automatic logic [31:0] memWord(input logic [31:0] adr);
        if ((adr >= resetPc) && (adr < resetPc + 4 * numInstr)) begin
            return prog[(adr - resetPc) >> 2];
        end
        return adr ^ 32'hA5A5_5A5A;
    endfunction

    // Result by funct3, alt selects SUB and SRA
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic buildProgram();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  badOp [0:5];
        int          kind;
        badOp = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100011, 7'b0100011, 7'b1110011};
        for (int n = 0; n < numInstr; n++) begin
            rd = $random(seed);
            rs1 = $random(seed);
            rs2 = $random(seed);
            f3 = $random(seed);
            imm = $random(seed);
            kind = $unsigned($random(seed)) % 8;
            // Extra weight on x0 as destination
            if (($unsigned($random(seed)) % 8) == 0) begin
                rd = 5'd0;
            end
            if (n < 31) begin
                prog[n] = {imm, 5'd0, 3'b000, 5'(n + 1), opOpImm};
            end else begin
                case (kind)
                    0, 1, 2: prog[n] = {1'b0, imm[10], 5'd0, rs2, rs1, f3, rd, opOp};
                    3, 4, 5: prog[n] = {imm, rs1, f3, rd, opOpImm};
                    6: begin
                        // Mostly LW, sometimes an unsupported width
                        f3 = (($unsigned($random(seed)) % 4) == 0) ? f3 : 3'b010;
                        prog[n] = {imm, rs1, f3, rd, opLoad};
                    end
                    default: prog[n] = {imm, rs1, f3, rd, badOp[$unsigned($random(seed)) % 6]};
                endcase
            end
        end
    endtask

    task automatic matchBusAddress(input string testName, input logic [31:0] expected);
        if (busAdrQ.size() == 0) begin
            errorCount++;
            $display("Instruction at pc %h retired without a matching bus access", modelPc);
        end else begin
            checkValue(testName, "bus address", expected, busAdrQ.pop_front());
        end
    endtask

    task automatic checkIdle(input string testName);
        checkValue(testName, "cyc", 32'd0, {31'd0, wbReq.cyc});
        checkValue(testName, "stb", 32'd0, {31'd0, wbReq.stb});
        checkValue(testName, "retireValid", 32'd0, {31'd0, retireValid});
    endtask

    // Step the reference model by one instruction and compare the trace
    task automatic checkRetire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] expVal;
        logic [31:0] ldAdr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        supported;
        logic        expWe;
        string       testName;
        ins = memWord(modelPc);
        rd = ins[11:7];
        f3 = ins[14:12];
        a = modelRegs[ins[19:15]];
        imm = {{20{ins[31]}}, ins[31:20]};
        supported = 1'b1;
        expVal = 32'd0;
        matchBusAddress("fetch", modelPc);
        case (ins[6:0])
            opOp: begin
                testName = "R-type";
                expVal = aluRef(f3, ins[30], a, modelRegs[ins[24:20]]);
            end
            opOpImm: begin
                testName = "OP-IMM";
                expVal = aluRef(f3, (f3 == 3'b101) && ins[30], a, imm);
            end
            opLoad: begin
                testName = (f3 == 3'b010) ? "load" : "no-op";
                supported = (f3 == 3'b010);
                if (supported) begin
                    ldAdr = (a + imm) & ~32'd3;
                    matchBusAddress(testName, ldAdr);
                    expVal = memWord(ldAdr);
                end
            end
            default: begin
                testName = "no-op";
                supported = 1'b0;
            end
        endcase
        expWe = supported && (rd != 5'd0);
        checkValue(testName, "pc", modelPc, retire.pc);
        checkValue(testName, "rd", {27'd0, rd}, {27'd0, retire.rd});
        checkValue(testName, "rdWe", {31'd0, expWe}, {31'd0, retire.rdWe});
        if (supported) begin
            checkValue(testName, "value", expVal, retire.value);
        end
        if (expWe) begin
            modelRegs[rd] = expVal;
        end
        modelPc = modelPc + 32'd4;
    endtask

    // Bus slave with 0 to 3 wait states
    always @(negedge clk) begin
        if (rst) begin
            wbRsp.ack = 1'b0;
            busBusy = 1'b0;
        end else if (wbRsp.ack) begin
            wbRsp.ack = 1'b0;
            busBusy = 1'b0;
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!busBusy) begin
                busBusy = 1'b1;
                waitLeft = $unsigned($random(seed)) % 4;
            end
            if (waitLeft == 0) begin
                wbRsp.ack = 1'b1;
                wbRsp.dat = memWord(wbReq.adr);
                busAdrQ.push_back(wbReq.adr);
                checkValue("bus", "we", 32'd0, {31'd0, wbReq.we});
                checkValue("bus", "sel", 32'hF, {28'd0, wbReq.sel});
                checkValue("bus", "write data", 32'd0, wbReq.dat);
            end else begin
                waitLeft--;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && retireValid && (retiredCount < numInstr)) begin
            checkRetire();
            retiredCount++;
        end
    end

    initial begin
        rst = 1'b1;
        wbRsp = '0;
        busBusy = 1'b0;
        waitLeft = 0;
        modelPc = resetPc;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        buildProgram();
        repeat (8) begin
            @(negedge clk);
            checkIdle("reset");
        end
        rst = 1'b0;
        checkIdle("after reset");
        wait (retiredCount == numInstr);
        @(negedge clk);
        $display("Retired %0d instructions, %0d checks, %0d errors, %0d assertion failures",
                 retiredCount, checkCount, errorCount, UUT.busChecks.failCount);
        if ((errorCount == 0) && (UUT.busChecks.failCount == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #timeoutNs;
        $display("Watchdog expired, core stopped retiring after %0d of %0d instructions",
                 retiredCount, numInstr);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/rvPkg.sv
src/aluControl.sv
src/alu.sv
src/regFile.sv
src/instrDecode.sv
src/coreControl.sv
src/execCore.sv
verif/execCore_sva.sv
verif/execCoreTb.sv
